// ==== build.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/pipe_reg.sv
rtl/mem_access.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/rv_backend.sv
testbench/rv_backend_props.sv
testbench/rv_backend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rv_backend testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module rv_backend_tb \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/Vrv_backend_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

// ==== testbench/rv_backend_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_backend_tb;

    localparam int CYCLE_LIMIT = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  ex_valid;
    rv_pipe_pkg::ex_mem_t  ex;
    rv_isa_pkg::reg_idx_t  e_rs1;
    rv_isa_pkg::reg_idx_t  e_rs2;
    logic [`RV_XLEN-1:0]   e_fwd_a;
    logic [`RV_XLEN-1:0]   e_fwd_b;
    logic                  load_use_stall;
    rv_pipe_pkg::wb_port_t wb;

    // reference model state.
    logic [31:0]           sreg [`RV_REG_COUNT];
    logic [7:0]            smem [`RV_DMEM_WORDS * 4];
    logic                  m_v;
    rv_pipe_pkg::ex_mem_t  m_ins;
    logic                  w_vld;
    rv_isa_pkg::reg_idx_t  w_rd;
    logic [31:0]           w_data;
    logic                  exp_stall;
    int                    last_stalls;
    int                    cycle_count;
    int                    error_count;
    integer                seed;
    string                 cur_test;

    rv_backend i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid       (ex_valid),
        .ex             (ex),
        .e_rs1          (e_rs1),
        .e_rs2          (e_rs2),
        .e_fwd_a        (e_fwd_a),
        .e_fwd_b        (e_fwd_b),
        .load_use_stall (load_use_stall),
        .wb             (wb)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
            abort_run("value mismatch");
        end
    endtask

    function automatic rv_pipe_pkg::ex_mem_t make_op(
        input rv_isa_pkg::result_src_e src,
        input rv_isa_pkg::reg_idx_t    rd,
        input logic [31:0]             alu,
        input logic [31:0]             aux,
        input rv_isa_pkg::mem_size_e   size,
        input logic                    regw,
        input logic                    memw
    );
        rv_pipe_pkg::ex_mem_t op;
        op.alu_result = alu;
        op.write_data = aux;
        op.imm_ext    = aux;
        op.pc_plus4   = alu + 32'd4;
        op.pc_target  = alu + aux;
        op.rd         = rd;
        op.result_src = src;
        op.mem_size   = size;
        op.reg_write  = regw;
        op.mem_write  = memw;
        return op;
    endfunction

    function automatic logic [31:0] result_of(input rv_pipe_pkg::ex_mem_t op);
        case (op.result_src)
            rv_isa_pkg::RES_PC4:    return op.pc_plus4;
            rv_isa_pkg::RES_IMM:    return op.imm_ext;
            rv_isa_pkg::RES_TARGET: return op.pc_target;
            default:                return op.alu_result;
        endcase
    endfunction

    // little-endian lanes with the low bits under the access size ignored.
    function automatic logic [31:0] load_value(input logic [31:0] addr,
                                               input rv_isa_pkg::mem_size_e size);
        logic [9:0] a;
        logic [9:0] h;
        logic [9:0] w;
        a = addr[9:0];
        h = {a[9:1], 1'b0};
        w = {a[9:2], 2'b00};
        case (size)
            rv_isa_pkg::MEM_B:  return {{24{smem[a][7]}}, smem[a]};
            rv_isa_pkg::MEM_BU: return {24'h0, smem[a]};
            rv_isa_pkg::MEM_H:  return {{16{smem[h+10'd1][7]}}, smem[h+10'd1], smem[h]};
            rv_isa_pkg::MEM_HU: return {16'h0, smem[h+10'd1], smem[h]};
            default: return {smem[w+10'd3], smem[w+10'd2], smem[w+10'd1], smem[w]};
        endcase
    endfunction

    task automatic store_bytes(input rv_pipe_pkg::ex_mem_t op);
        logic [9:0] a;
        a = op.alu_result[9:0];
        case (op.mem_size)
            rv_isa_pkg::MEM_B: smem[a] = op.write_data[7:0];
            rv_isa_pkg::MEM_H: begin
                a = {a[9:1], 1'b0};
                smem[a]       = op.write_data[7:0];
                smem[a+10'd1] = op.write_data[15:8];
            end
            default: begin
                a = {a[9:2], 2'b00};
                for (int i = 0; i < 4; i++) begin
                    smem[a+10'(i)] = op.write_data[i*8 +: 8];
                end
            end
        endcase
    endtask

    function automatic logic [31:0] fwd_value(input rv_isa_pkg::reg_idx_t rs);
        if (rs == '0) begin
            return 32'h0;
        end
        if (m_v && m_ins.reg_write && m_ins.rd == rs &&
            m_ins.result_src != rv_isa_pkg::RES_MEM) begin
            return result_of(m_ins);
        end
        if (w_vld && w_rd == rs) begin
            return w_data;
        end
        return sreg[rs];
    endfunction

    task automatic advance_model();
        if (w_vld) begin
            sreg[w_rd] = w_data;
        end
        w_vld  = m_v && m_ins.reg_write && (m_ins.rd != '0);
        w_rd   = m_ins.rd;
        w_data = (m_ins.result_src == rv_isa_pkg::RES_MEM) ?
                 load_value(m_ins.alu_result, m_ins.mem_size) : result_of(m_ins);
        if (m_v && m_ins.mem_write) begin
            store_bytes(m_ins);
        end
        m_v   = ex_valid && !exp_stall;
        m_ins = ex;
    endtask

    // one clock of model update and drive with every compare at the falling edge.
    task automatic step(input logic v, input rv_pipe_pkg::ex_mem_t op,
                        input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2);
        @(posedge clk);
        advance_model();
        ex_valid <= v;
        ex       <= op;
        e_rs1    <= rs1;
        e_rs2    <= rs2;
        @(negedge clk);
        exp_stall = m_v && m_ins.reg_write && (m_ins.rd != '0) &&
                    (m_ins.result_src == rv_isa_pkg::RES_MEM) &&
                    (m_ins.rd == e_rs1 || m_ins.rd == e_rs2);
        check_value("wb.valid", {31'h0, w_vld}, {31'h0, wb.valid});
        if (w_vld) begin
            check_value("wb.rd", {27'h0, w_rd}, {27'h0, wb.rd});
            check_value("wb.data", w_data, wb.data);
        end
        check_value("load_use_stall", {31'h0, exp_stall}, {31'h0, load_use_stall});
        check_value("e_fwd_a", fwd_value(e_rs1), e_fwd_a);
        check_value("e_fwd_b", fwd_value(e_rs2), e_fwd_b);
    endtask

    task automatic idle(input int n, input rv_isa_pkg::reg_idx_t rs1,
                        input rv_isa_pkg::reg_idx_t rs2);
        for (int i = 0; i < n; i++) begin
            step(1'b0, '0, rs1, rs2);
        end
    endtask

    // holds the instruction while the stall is up.
    task automatic issue(input rv_pipe_pkg::ex_mem_t op, input rv_isa_pkg::reg_idx_t rs1,
                         input rv_isa_pkg::reg_idx_t rs2);
        last_stalls = 0;
        step(1'b1, op, rs1, rs2);
        while (load_use_stall) begin
            last_stalls++;
            step(1'b1, op, rs1, rs2);
        end
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        for (int r = 0; r < 32; r += 5) begin
            step(1'b0, '0, 5'(r), 5'(31 - r));
            check_value("wb.valid", 32'h0, {31'h0, wb.valid});
            check_value("load_use_stall", 32'h0, {31'h0, load_use_stall});
            check_value("e_fwd_a", 32'h0, e_fwd_a);
            check_value("e_fwd_b", 32'h0, e_fwd_b);
        end
    endtask

    task automatic test_result_select();
        logic [31:0] expv [5];
        cur_test = "test_result_select";
        expv[1] = 32'h1234_5678;
        expv[2] = 32'h0000_1004;
        expv[3] = 32'h0000_0abc;
        expv[4] = 32'h0000_2040;
        issue(make_op(rv_isa_pkg::RES_ALU, 5'd1, 32'h1234_5678, 32'h0,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        issue(make_op(rv_isa_pkg::RES_PC4, 5'd2, 32'h0000_1000, 32'h0,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        issue(make_op(rv_isa_pkg::RES_IMM, 5'd3, 32'h0, 32'h0000_0abc,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        issue(make_op(rv_isa_pkg::RES_TARGET, 5'd4, 32'h0000_2000, 32'h0000_0040,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        issue(make_op(rv_isa_pkg::RES_ALU, 5'd0, 32'hdead_beef, 32'h0,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        idle(3, '0, '0);
        for (int r = 1; r < 5; r++) begin
            step(1'b0, '0, 5'(r), '0);
            check_value("register readback", expv[r], e_fwd_a);
        end
    endtask

    task automatic test_load_store();
        cur_test = "test_load_store";
        issue(make_op(rv_isa_pkg::RES_ALU, '0, 32'h44, 32'h8765_4321,
                      rv_isa_pkg::MEM_W, 1'b0, 1'b1), '0, '0);
        for (int o = 0; o < 4; o += 2) begin
            issue(make_op(rv_isa_pkg::RES_ALU, '0, 32'h48 + 32'(o), 32'h0000_f00d + 32'(o),
                          rv_isa_pkg::MEM_H, 1'b0, 1'b1), '0, '0);
        end
        for (int o = 0; o < 4; o++) begin
            issue(make_op(rv_isa_pkg::RES_ALU, '0, 32'h40 + 32'(o), 32'h0000_007e + 32'(o * 3),
                          rv_isa_pkg::MEM_B, 1'b0, 1'b1), '0, '0);
        end
        idle(2, '0, '0);
        for (int a = 32'h40; a < 32'h4c; a++) begin
            issue(make_op(rv_isa_pkg::RES_MEM, 5'd5, 32'(a), 32'h0,
                          rv_isa_pkg::MEM_B, 1'b1, 1'b0), '0, '0);
            issue(make_op(rv_isa_pkg::RES_MEM, 5'd6, 32'(a), 32'h0,
                          rv_isa_pkg::MEM_BU, 1'b1, 1'b0), '0, '0);
            issue(make_op(rv_isa_pkg::RES_MEM, 5'd7, 32'(a), 32'h0,
                          rv_isa_pkg::MEM_H, 1'b1, 1'b0), '0, '0);
            issue(make_op(rv_isa_pkg::RES_MEM, 5'd8, 32'(a), 32'h0,
                          rv_isa_pkg::MEM_HU, 1'b1, 1'b0), '0, '0);
            issue(make_op(rv_isa_pkg::RES_MEM, 5'd9, 32'(a), 32'h0,
                          rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        end
        idle(3, 5'd5, 5'd9);
    endtask

    task automatic test_bypass();
        cur_test = "test_bypass";
        for (int i = 0; i < 6; i++) begin
            issue(make_op(rv_isa_pkg::RES_ALU, 5'd10, 32'hb000_0000 + 32'(i), 32'h0,
                          rv_isa_pkg::MEM_W, 1'b1, 1'b0), 5'd10, 5'd10);
        end
        idle(1, 5'd10, 5'd11);
        idle(3, 5'd11, 5'd10);
    endtask

    task automatic test_load_use();
        cur_test = "test_load_use";
        issue(make_op(rv_isa_pkg::RES_ALU, '0, 32'h80, 32'hcafe_f00d,
                      rv_isa_pkg::MEM_W, 1'b0, 1'b1), '0, '0);
        idle(2, '0, '0);
        issue(make_op(rv_isa_pkg::RES_MEM, 5'd12, 32'h80, 32'h0,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), '0, '0);
        issue(make_op(rv_isa_pkg::RES_ALU, 5'd13, 32'h1, 32'h0,
                      rv_isa_pkg::MEM_W, 1'b1, 1'b0), 5'd12, 5'd0);
        check_value("stall cycles", 32'd1, 32'(last_stalls));
        check_value("forwarded load", 32'hcafe_f00d, e_fwd_a);
        idle(3, 5'd12, 5'd13);
    endtask

    task automatic test_random_mix();
        logic [31:0]          r;
        logic [31:0]          v;
        logic [31:0]          addr;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs_a;
        rv_isa_pkg::reg_idx_t rs_b;
        rv_isa_pkg::mem_size_e size;
        cur_test = "test_random_mix";
        for (int a = 32'h100; a < 32'h120; a += 4) begin
            issue(make_op(rv_isa_pkg::RES_ALU, '0, 32'(a), $random(seed),
                          rv_isa_pkg::MEM_W, 1'b0, 1'b1), '0, '0);
        end
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            v    = $random(seed);
            addr = 32'h100 + {27'h0, v[4:0]};
            rd   = {2'b00, r[10:8]};
            rs_a = {2'b00, r[13:11]};
            rs_b = {2'b00, r[16:14]};
            case (r[2:0])
                3'd0: issue(make_op(rv_isa_pkg::RES_ALU, rd, v, 32'h0,
                                    rv_isa_pkg::MEM_W, 1'b1, 1'b0), rs_a, rs_b);
                3'd1: issue(make_op(rv_isa_pkg::RES_PC4, rd, v, 32'h0,
                                    rv_isa_pkg::MEM_W, 1'b1, 1'b0), rs_a, rs_b);
                3'd2: issue(make_op(rv_isa_pkg::RES_IMM, rd, 32'h0, v,
                                    rv_isa_pkg::MEM_W, 1'b1, 1'b0), rs_a, rs_b);
                3'd3: issue(make_op(rv_isa_pkg::RES_TARGET, rd, v, 32'h10,
                                    rv_isa_pkg::MEM_W, 1'b1, 1'b0), rs_a, rs_b);
                3'd4, 3'd5: begin
                    size = (r[4:3] == 2'd0) ? rv_isa_pkg::MEM_B :
                           (r[4:3] == 2'd1) ? rv_isa_pkg::MEM_H : rv_isa_pkg::MEM_W;
                    issue(make_op(rv_isa_pkg::RES_ALU, '0, addr, $random(seed),
                                  size, 1'b0, 1'b1), rs_a, rs_b);
                end
                default: begin
                    case (r[5:3])
                        3'd0: size = rv_isa_pkg::MEM_B;
                        3'd1: size = rv_isa_pkg::MEM_H;
                        3'd2: size = rv_isa_pkg::MEM_BU;
                        3'd3: size = rv_isa_pkg::MEM_HU;
                        default: size = rv_isa_pkg::MEM_W;
                    endcase
                    issue(make_op(rv_isa_pkg::RES_MEM, rd, addr, 32'h0,
                                  size, 1'b1, 1'b0), rs_a, rs_b);
                end
            endcase
        end
        idle(3, 5'd1, 5'd2);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        ex_valid    = 1'b0;
        ex          = '0;
        e_rs1       = '0;
        e_rs2       = '0;
        m_v         = 1'b0;
        m_ins       = '0;
        w_vld       = 1'b0;
        w_rd        = '0;
        w_data      = '0;
        exp_stall   = 1'b0;
        last_stalls = 0;
        cycle_count = 0;
        error_count = 0;
        seed        = 32'h818e_6db4;
        cur_test    = "startup";
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            sreg[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_result_select();
        test_load_store();
        test_bypass();
        test_load_use();
        test_random_mix();
        if (error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rv_backend_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_backend_props (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire rv_pipe_pkg::wb_port_t wb,
    input wire logic                  load_use_stall
);

    // x0 is never a writeback target.
    a_wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> (wb.rd != '0)
    ) else $error("writeback valid with rd equal to zero");

    // the bubble behind a load clears the hazard.
    a_stall_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_use_stall |=> !load_use_stall
    ) else $error("load-use stall high in two consecutive cycles");

    a_wb_quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n |-> !wb.valid
    ) else $error("writeback valid while reset is asserted");

endmodule

bind rv_backend rv_backend_props i_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb             (wb),
    .load_use_stall (load_use_stall)
);

`default_nettype wire

// ==== rtl/rv_backend.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module rv_backend (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 ex_valid,
    input  wire rv_pipe_pkg::ex_mem_t ex,
    input  wire rv_isa_pkg::reg_idx_t e_rs1,
    input  wire rv_isa_pkg::reg_idx_t e_rs2,
    output logic [`RV_XLEN-1:0]       e_fwd_a,
    output logic [`RV_XLEN-1:0]       e_fwd_b,
    output logic                      load_use_stall,
    output rv_pipe_pkg::wb_port_t     wb
);

    logic                 m_valid;
    rv_pipe_pkg::ex_mem_t m;
    logic [`RV_XLEN-1:0]  m_result;
    rv_pipe_pkg::mem_wb_t m_next;
    logic                 w_valid;
    rv_pipe_pkg::mem_wb_t w;
    logic [`RV_XLEN-1:0]  rd1;
    logic [`RV_XLEN-1:0]  rd2;

    // bubble on a load-use stall.
    pipe_reg #(
        .payload_t (rv_pipe_pkg::ex_mem_t)
    ) i_ex_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .bubble  (load_use_stall),
        .d_valid (ex_valid),
        .d       (ex),
        .q_valid (m_valid),
        .q       (m)
    );

    mem_access i_mem_access (
        .clk      (clk),
        .rst_n    (rst_n),
        .m_valid  (m_valid),
        .m        (m),
        .w_valid  (w_valid),
        .w        (w),
        .m_result (m_result),
        .m_next   (m_next),
        .wb       (wb)
    );

    pipe_reg #(
        .payload_t (rv_pipe_pkg::mem_wb_t)
    ) i_mem_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .bubble  (1'b0),
        .d_valid (m_valid),
        .d       (m_next),
        .q_valid (w_valid),
        .q       (w)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb),
        .rs1   (e_rs1),
        .rs2   (e_rs2),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    operand_bypass i_operand_bypass (
        .e_rs1          (e_rs1),
        .e_rs2          (e_rs2),
        .m_valid        (m_valid),
        .m              (m),
        .m_result       (m_result),
        .wb             (wb),
        .rd1            (rd1),
        .rd2            (rd2),
        .e_fwd_a        (e_fwd_a),
        .e_fwd_b        (e_fwd_b),
        .load_use_stall (load_use_stall)
    );

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module operand_bypass (
    input  wire rv_isa_pkg::reg_idx_t  e_rs1,
    input  wire rv_isa_pkg::reg_idx_t  e_rs2,
    input  wire logic                  m_valid,
    input  wire rv_pipe_pkg::ex_mem_t  m,
    input  wire logic [`RV_XLEN-1:0]   m_result,
    input  wire rv_pipe_pkg::wb_port_t wb,
    input  wire logic [`RV_XLEN-1:0]   rd1,
    input  wire logic [`RV_XLEN-1:0]   rd2,
    output logic [`RV_XLEN-1:0]        e_fwd_a,
    output logic [`RV_XLEN-1:0]        e_fwd_b,
    output logic                       load_use_stall
);

    logic m_writes;
    logic m_is_load;

    assign m_writes  = m_valid & m.reg_write & (m.rd != '0);
    assign m_is_load = (m.result_src == rv_isa_pkg::RES_MEM);

    // youngest producer wins.
    function automatic logic [`RV_XLEN-1:0] pick(
        input rv_isa_pkg::reg_idx_t rs,
        input logic [`RV_XLEN-1:0]  rf_val
    );
        logic [`RV_XLEN-1:0] val;
        if (rs == '0) begin
            val = '0;
        end else if (m_writes && !m_is_load && m.rd == rs) begin
            val = m_result;
        end else if (wb.valid && wb.rd == rs) begin
            val = wb.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign e_fwd_a = pick(e_rs1, rd1);
    assign e_fwd_b = pick(e_rs2, rd2);

    // load data only exists one stage later.
    // the bubble behind it clears this next cycle.
    assign load_use_stall = m_writes & m_is_load &
                            ((m.rd == e_rs1) | (m.rd == e_rs2));

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rv_pipe_pkg::wb_port_t wb,
    input  wire rv_isa_pkg::reg_idx_t  rs1,
    input  wire rv_isa_pkg::reg_idx_t  rs2,
    output logic [`RV_XLEN-1:0]        rd1,
    output logic [`RV_XLEN-1:0]        rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // asynchronous read.
    // same-cycle writes are covered by the bypass.
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/mem_access.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defs.svh"

module mem_access (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 m_valid,
    input  wire rv_pipe_pkg::ex_mem_t m,
    input  wire logic                 w_valid,
    input  wire rv_pipe_pkg::mem_wb_t w,
    output logic [`RV_XLEN-1:0]       m_result,
    output rv_pipe_pkg::mem_wb_t      m_next,
    output rv_pipe_pkg::wb_port_t     wb
);

    localparam int LANES = `RV_XLEN / 8;

    logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] word_addr;
    logic [1:0]             byte_off;
    logic [LANES-1:0]       store_be;
    logic [`RV_XLEN-1:0]    store_data;
    logic [`RV_XLEN-1:0]    load_word;
    logic [`RV_XLEN-1:0]    load_ext;
    logic [`RV_XLEN-1:0]    shifted;

    assign word_addr = m.alu_result[`RV_DMEM_AW+1:2];
    assign byte_off  = m.alu_result[1:0];

    // byte lanes with the low bits under the access size dropped.
    always_comb begin
        store_be   = '0;
        store_data = m.write_data;
        case (m.mem_size)
            rv_isa_pkg::MEM_B: begin
                store_be   = 4'b0001 << byte_off;
                store_data = {LANES{m.write_data[7:0]}};
            end
            rv_isa_pkg::MEM_H: begin
                store_be   = 4'b0011 << {byte_off[1], 1'b0};
                store_data = {(LANES / 2){m.write_data[15:0]}};
            end
            default: begin
                store_be = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (m_valid && m.mem_write) begin
            for (int i = 0; i < LANES; i++) begin
                if (store_be[i]) begin
                    dmem[word_addr][i*8 +: 8] <= store_data[i*8 +: 8];
                end
            end
        end
    end

    // synchronous read for the writeback stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_word <= '0;
        end else begin
            load_word <= dmem[word_addr];
        end
    end

    always_comb begin
        case (m.result_src)
            rv_isa_pkg::RES_PC4:    m_result = m.pc_plus4;
            rv_isa_pkg::RES_IMM:    m_result = m.imm_ext;
            rv_isa_pkg::RES_TARGET: m_result = m.pc_target;
            default:                m_result = m.alu_result;
        endcase
    end

    always_comb begin
        m_next.result    = m_result;
        m_next.byte_off  = byte_off;
        m_next.mem_size  = m.mem_size;
        m_next.is_load   = (m.result_src == rv_isa_pkg::RES_MEM);
        m_next.rd        = m.rd;
        m_next.reg_write = m.reg_write;
    end

    assign shifted = load_word >> {w.byte_off, 3'b000};

    always_comb begin
        case (w.mem_size)
            rv_isa_pkg::MEM_B:  load_ext = {{(`RV_XLEN-8){shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::MEM_BU: load_ext = {{(`RV_XLEN-8){1'b0}}, shifted[7:0]};
            rv_isa_pkg::MEM_H: begin
                load_ext = (w.byte_off[1]) ?
                    {{(`RV_XLEN-16){load_word[31]}}, load_word[31:16]} :
                    {{(`RV_XLEN-16){load_word[15]}}, load_word[15:0]};
            end
            rv_isa_pkg::MEM_HU: begin
                load_ext = (w.byte_off[1]) ?
                    {{(`RV_XLEN-16){1'b0}}, load_word[31:16]} :
                    {{(`RV_XLEN-16){1'b0}}, load_word[15:0]};
            end
            default:            load_ext = load_word;
        endcase
    end

    // x0 writes never leave the stage.
    assign wb.valid = w_valid & w.reg_write & (w.rd != '0);
    assign wb.rd    = w.rd;
    assign wb.data  = (w.is_load) ? load_ext : w.result;

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     bubble,
    input  wire logic     d_valid,
    input  wire payload_t d,
    output logic          q_valid,
    output payload_t      q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            // a stalled cycle drops the slot.
            q_valid <= d_valid & ~bubble;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pipe_pkg;

    // execute to memory stage.
    typedef struct packed {
        logic [`RV_XLEN-1:0]     alu_result;
        logic [`RV_XLEN-1:0]     write_data;
        logic [`RV_XLEN-1:0]     imm_ext;
        logic [`RV_XLEN-1:0]     pc_plus4;
        logic [`RV_XLEN-1:0]     pc_target;
        rv_isa_pkg::reg_idx_t    rd;
        rv_isa_pkg::result_src_e result_src;
        rv_isa_pkg::mem_size_e   mem_size;
        logic                    reg_write;
        logic                    mem_write;
    } ex_mem_t;

    // memory to writeback stage.
    // load data itself arrives from the memory read register.
    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic [1:0]            byte_off;
        rv_isa_pkg::mem_size_e mem_size;
        logic                  is_load;
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
    } mem_wb_t;

    // register file write port.
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::reg_idx_t rd;
        logic [`RV_XLEN-1:0]  data;
    } wb_port_t;

endpackage

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // register index from x0 to x31.
    typedef logic [4:0] reg_idx_t;

    // what the instruction writes back.
    typedef enum logic [2:0] {
        RES_ALU    = 3'd0,
        RES_MEM    = 3'd1,
        RES_PC4    = 3'd2,
        RES_IMM    = 3'd3,
        RES_TARGET = 3'd4
    } result_src_e;

    // funct3 of loads and stores.
    // stores only use B, H and W.
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

endpackage

`default_nettype wire

// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and address width.
`define RV_XLEN 32

// architectural integer registers including x0.
`define RV_REG_COUNT 32

// data memory size in 32-bit words.
`define RV_DMEM_WORDS 256

// word index width as log2 of RV_DMEM_WORDS.
`define RV_DMEM_AW 8

`endif
